// File: common/spw_link_pkg.sv
package spw_link_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // credit accounting for the FCT handshake
  ////////////////////////////////////////////////////////////////////////////

  localparam int CREDIT_W   = 6;   // count of outstanding n-chars
  localparam int CREDIT_MAX = 56;  // seven FCTs worth
  localparam int FCT_CREDIT = 8;   // one FCT grants eight n-chars

  // no transition on D or S for this many gclk cycles means the link is gone
  // 22 cycles at 40 ns is roughly the 850 ns of the standard
  localparam int DSC_TIMEOUT = 22;
  localparam int DSC_CNT_W   = $clog2(DSC_TIMEOUT);

  ////////////////////////////////////////////////////////////////////////////
  // link level reporting
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic parity;      // parity check failed
    logic escape;      // ESC followed by EOP, EEP or ESC
    logic disconnect;  // line went quiet
  } rx_err_t;

  typedef struct packed {
    logic got_fct;     // lone FCT seen
    logic got_nchar;   // data, EOP or EEP seen
    logic got_time;    // time code seen
  } rx_event_t;

endpackage

// File: common/spw_char_pkg.sv
package spw_char_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // character layout on the wire
  ////////////////////////////////////////////////////////////////////////////

  // bit order: parity, flag, then the rest lsb first
  localparam int PAR_POS  = 0;
  localparam int FLAG_POS = 1;

  localparam int CTRL_LEN = 4;   // flag 1
  localparam int DATA_LEN = 10;  // flag 0

  localparam int BIT_CNT_W = $clog2(DATA_LEN);  // bit index inside a character

  // 2-bit control codes, sent lsb first after the flag
  localparam logic [1:0] CODE_FCT = 2'b00;
  localparam logic [1:0] CODE_EOP = 2'b01;
  localparam logic [1:0] CODE_EEP = 2'b10;
  localparam logic [1:0] CODE_ESC = 2'b11;

  // NULL as received after its first parity bit, oldest bit at index 0
  // flag, ESC code, parity 0, flag, FCT code
  localparam logic [6:0] NULL_BITS = {
    CODE_FCT[1], CODE_FCT[0],  // fct code
    1'b1,                      // flag of the FCT
    1'b0,                      // parity of the FCT
    CODE_ESC[1], CODE_ESC[0],  // esc code
    1'b1                       // flag of the ESC
  };

  ////////////////////////////////////////////////////////////////////////////
  // character types
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [1:0] ctrl;   // control flags of the time code
    logic [5:0] value;  // time counter
  } time_code_t;

  // 8 bits after the flag, a byte for data, a time code after ESC
  typedef union packed {
    logic [7:0] data;
    time_code_t tc;
  } payload_u;

  typedef struct packed {
    logic       is_ctrl;  // flag bit
    logic [1:0] code;     // valid when is_ctrl
    payload_u   payload;  // valid when !is_ctrl
  } rx_char_t;

  // fifo word, EOP is marker with 0, EEP marker with 1
  typedef struct packed {
    logic       is_marker;
    logic [7:0] data;
  } nchar_t;

endpackage

// File: design/ds_line_monitor.sv
`timescale 1ns/1ps

module ds_line_monitor (
  input  logic gclk,
  input  logic reset,
  input  logic d_i,
  input  logic s_i,
  output logic bit_valid_o,
  output logic bit_o,
  output logic link_dsc_o,
  output logic err_dsc_o
);
  import spw_link_pkg::*;

  logic [1:0]           d_sync;   // [0] first stage, [1] second stage
  logic [1:0]           s_sync;
  logic                 d_last;   // previous synchronized values
  logic                 s_last;
  logic                 armed;    // timeout runs only once bits have arrived
  logic [DSC_CNT_W-1:0] dsc_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // synchronizer and transition detect
  ////////////////////////////////////////////////////////////////////////////

  // every transition on D or S carries exactly one bit, D holds its value
  always_ff @(posedge gclk)
  begin
    if (reset)
    begin
      d_sync      <= '0;
      s_sync      <= '0;
      d_last      <= 1'b0;
      s_last      <= 1'b0;
      bit_valid_o <= 1'b0;
      bit_o       <= 1'b0;
    end
    else
    begin
      d_sync      <= {d_sync[0], d_i};
      s_sync      <= {s_sync[0], s_i};
      d_last      <= d_sync[1];
      s_last      <= s_sync[1];
      bit_valid_o <= (d_sync[1] ^ d_last) | (s_sync[1] ^ s_last);  // third cycle
      bit_o       <= d_sync[1];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // disconnect timeout
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge gclk)
  begin
    if (reset)
    begin
      armed      <= 1'b0;
      dsc_cnt    <= '0;
      link_dsc_o <= 1'b0;
      err_dsc_o  <= 1'b0;
    end
    else
    begin
      err_dsc_o <= 1'b0;
      if (bit_valid_o)
      begin
        armed   <= 1'b1;  // first strobe arms the timer
        dsc_cnt <= '0;    // each strobe restarts it
      end
      else if (armed && !link_dsc_o)
      begin
        // fires DSC_TIMEOUT cycles after the strobe
        if (dsc_cnt == DSC_CNT_W'(DSC_TIMEOUT - 2))
        begin
          link_dsc_o <= 1'b1;  // sticky until reset
          err_dsc_o  <= 1'b1;  // single pulse
        end
        else
          dsc_cnt <= dsc_cnt + 1'b1;
      end
    end
  end

endmodule

// File: char_rx/char_assembler.sv
`timescale 1ns/1ps

module char_assembler (
  input  logic                   gclk,
  input  logic                   reset,
  input  logic                   enable_i,
  input  logic                   bit_valid_i,
  input  logic                   bit_i,
  output logic                   char_valid_o,
  output spw_char_pkg::rx_char_t char_o,
  output logic                   err_par_o,
  output logic                   aligned_o
);
  import spw_char_pkg::*;

  logic [5:0]           hunt_q;    // last six bits, newest at the top
  logic [DATA_LEN-1:0]  buf_q;     // character bits by position
  logic [DATA_LEN-1:0]  buf_nxt;
  logic [BIT_CNT_W-1:0] bit_cnt;   // position of the next bit
  logic                 par_acc;   // xor of bits after the previous flag
  logic                 halted;    // parity error seen
  logic                 take;
  logic                 pre_hit;   // NULL seen up to the first FCT code bit
  logic                 null_hit;  // whole NULL seen
  logic                 char_end;  // this bit closes the character

  assign take     = bit_valid_i & enable_i & ~halted;
  assign pre_hit  = ({bit_i, hunt_q[5:1]} == NULL_BITS[5:0]);
  assign null_hit = ({bit_i, hunt_q} == NULL_BITS);

  // length follows the stored flag, only looked at past the flag
  assign char_end = (bit_cnt == (buf_q[FLAG_POS] ? BIT_CNT_W'(CTRL_LEN - 1)
                                                 : BIT_CNT_W'(DATA_LEN - 1)));

  always_comb
  begin
    buf_nxt          = buf_q;
    buf_nxt[bit_cnt] = bit_i;  // incoming bit dropped into its slot
  end

  ////////////////////////////////////////////////////////////////////////////
  // hunt, bit count and running parity
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge gclk)
  begin
    if (reset)
    begin
      hunt_q       <= '0;
      bit_cnt      <= '0;
      par_acc      <= 1'b0;
      halted       <= 1'b0;
      aligned_o    <= 1'b0;
      char_valid_o <= 1'b0;
      err_par_o    <= 1'b0;
    end
    else
    begin
      char_valid_o <= 1'b0;
      err_par_o    <= 1'b0;
      if (take)
      begin
        if (!aligned_o)
        begin
          hunt_q <= {bit_i, hunt_q[5:1]};
          if (null_hit)
          begin
            aligned_o    <= 1'b1;                 // boundaries known from here
            char_valid_o <= 1'b1;                 // the FCT half of the NULL
            par_acc      <= bit_i ^ hunt_q[5];    // FCT code bits
            bit_cnt      <= '0;
          end
          else if (pre_hit)
            char_valid_o <= 1'b1;                 // ESC half, decoder keeps it pending
        end
        else if (bit_cnt == BIT_CNT_W'(FLAG_POS))
        begin
          // odd ones over previous tail, parity and flag
          if (!(par_acc ^ buf_q[PAR_POS] ^ bit_i))
          begin
            err_par_o <= 1'b1;
            halted    <= 1'b1;                    // no decoding until reset
          end
          par_acc <= 1'b0;                        // new tail starts after the flag
          bit_cnt <= bit_cnt + 1'b1;
        end
        else
        begin
          if (bit_cnt != BIT_CNT_W'(PAR_POS))
            par_acc <= par_acc ^ bit_i;
          if (char_end)
          begin
            char_valid_o <= 1'b1;
            bit_cnt      <= '0;
          end
          else
            bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // character register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge gclk)
  begin
    if (take)
    begin
      buf_q <= buf_nxt;
      if (!aligned_o)
      begin
        char_o.is_ctrl <= 1'b1;
        char_o.code    <= null_hit ? CODE_FCT : CODE_ESC;
        char_o.payload <= '0;
      end
      else
      begin
        char_o.is_ctrl      <= buf_nxt[FLAG_POS];
        char_o.code         <= buf_nxt[FLAG_POS+2:FLAG_POS+1];
        char_o.payload.data <= buf_nxt[FLAG_POS+8:FLAG_POS+1];  // lsb first on the wire
      end
    end
  end

endmodule

// File: char_rx/char_decoder.sv
`timescale 1ns/1ps

module char_decoder (
  input  logic                    gclk,
  input  logic                    reset,
  input  logic                    char_valid_i,
  input  spw_char_pkg::rx_char_t  char_i,
  input  logic                    aligned_i,
  input  logic                    link_run_i,
  input  logic                    fifo_full_i,
  output spw_link_pkg::rx_event_t event_o,
  output logic                    err_esc_o,
  output logic                    got_null_o,
  output logic                    fifo_wr_o,
  output spw_char_pkg::nchar_t    nchar_o,
  output logic                    tick_o,
  output spw_char_pkg::payload_u  time_o
);
  import spw_char_pkg::*;

  logic esc_pend;   // ESC waiting for its partner
  logic halted;     // escape error seen
  logic wr_pend;    // n-char ready for the fifo this cycle
  logic accept;
  logic is_esc;
  logic is_fct;

  assign accept = char_valid_i & ~halted;
  assign is_esc = char_i.is_ctrl & (char_i.code == CODE_ESC);
  assign is_fct = char_i.is_ctrl & (char_i.code == CODE_FCT);

  // full and run are looked at in the write cycle itself
  assign fifo_wr_o = wr_pend & link_run_i & ~fifo_full_i;

  always_ff @(posedge gclk)
  begin
    if (reset)
    begin
      esc_pend   <= 1'b0;
      halted     <= 1'b0;
      wr_pend    <= 1'b0;
      got_null_o <= 1'b0;
      event_o    <= '0;
      err_esc_o  <= 1'b0;
      tick_o     <= 1'b0;
      nchar_o    <= '0;
      time_o     <= '0;
    end
    else
    begin
      event_o   <= '0;  // pulses
      err_esc_o <= 1'b0;
      tick_o    <= 1'b0;
      wr_pend   <= 1'b0;
      if (accept)
      begin
        if (!aligned_i)
          esc_pend <= is_esc;  // only the NULL's ESC arrives while hunting
        else if (esc_pend)
        begin
          esc_pend <= 1'b0;
          if (!char_i.is_ctrl)
          begin
            event_o.got_time <= 1'b1;               // ESC + data is a time code
            tick_o           <= link_run_i;
            time_o.tc.ctrl   <= char_i.payload.tc.ctrl;
            time_o.tc.value  <= char_i.payload.tc.value;
          end
          else if (is_fct)
            got_null_o <= 1'b1;                     // stays set
          else
          begin
            err_esc_o <= 1'b1;                      // ESC + EOP, EEP or ESC
            halted    <= 1'b1;
          end
        end
        else if (is_esc)
          esc_pend <= 1'b1;
        else if (is_fct)
          event_o.got_fct <= 1'b1;
        else
        begin
          // data, EOP or EEP
          event_o.got_nchar <= 1'b1;
          wr_pend           <= 1'b1;
          nchar_o.is_marker <= char_i.is_ctrl;
          nchar_o.data      <= char_i.is_ctrl ? {7'b0, char_i.code == CODE_EEP}
                                              : char_i.payload.data;
        end
      end
    end
  end

endmodule

// File: design/credit_counter.sv
`timescale 1ns/1ps

module credit_counter (
  input  logic                              gclk,
  input  logic                              reset,
  input  logic                              link_dsc_i,
  input  logic                              fct_sent_i,
  input  logic                              got_nchar_i,
  output logic [spw_link_pkg::CREDIT_W-1:0] credit_o,
  output logic                              fct_request_o
);
  import spw_link_pkg::*;

  localparam logic [CREDIT_W-1:0] ROOM_LVL = CREDIT_W'(CREDIT_MAX - FCT_CREDIT);  // 48

  logic                add_ok;      // FCT still fits under CREDIT_MAX
  logic                sub_ok;      // n-char consumes one credit
  logic [CREDIT_W-1:0] credit_nxt;

  assign add_ok = fct_sent_i & (credit_o <= ROOM_LVL);
  assign sub_ok = got_nchar_i & (add_ok | (credit_o != '0));  // floor at zero

  always_comb
  begin
    credit_nxt = credit_o;
    if (add_ok)
      credit_nxt = credit_nxt + CREDIT_W'(FCT_CREDIT);
    if (sub_ok)
      credit_nxt = credit_nxt - 1'b1;
    if (link_dsc_i)
      credit_nxt = '0;  // disconnect forgets all credit
  end

  always_ff @(posedge gclk)
  begin
    if (reset)
    begin
      credit_o      <= '0;
      fct_request_o <= 1'b0;
    end
    else
    begin
      credit_o      <= credit_nxt;
      fct_request_o <= (credit_nxt <= ROOM_LVL);  // room for eight more
    end
  end

endmodule

// File: design/spw_receiver.sv
`timescale 1ns/1ps

module spw_receiver (
  input  logic                              gclk,
  input  logic                              reset,
  input  logic                              d_i,
  input  logic                              s_i,
  input  logic                              rx_enable_i,
  input  logic                              link_run_i,
  input  logic                              fct_sent_i,
  input  logic                              fifo_full_i,
  output logic                              fifo_wr_o,
  output spw_char_pkg::nchar_t              nchar_o,
  output logic                              tick_o,
  output spw_char_pkg::payload_u            time_o,
  output spw_link_pkg::rx_event_t           event_o,
  output spw_link_pkg::rx_err_t             err_o,
  output logic                              got_null_o,
  output logic                              link_dsc_o,
  output logic [spw_link_pkg::CREDIT_W-1:0] credit_o,
  output logic                              fct_request_o
);
  import spw_char_pkg::*;

  logic     bit_valid;   // one strobe per line transition
  logic     rx_bit;
  logic     err_dsc;
  logic     char_valid;
  rx_char_t rx_char;
  logic     err_par;
  logic     aligned;     // first NULL found
  logic     err_esc;

  ////////////////////////////////////////////////////////////////////////////
  // line -> bits -> characters -> events
  ////////////////////////////////////////////////////////////////////////////

  ds_line_monitor u_line (
    .gclk        (gclk),
    .reset       (reset),
    .d_i         (d_i),
    .s_i         (s_i),
    .bit_valid_o (bit_valid),
    .bit_o       (rx_bit),
    .link_dsc_o  (link_dsc_o),
    .err_dsc_o   (err_dsc)
  );

  char_assembler u_asm (
    .gclk         (gclk),
    .reset        (reset),
    .enable_i     (rx_enable_i),
    .bit_valid_i  (bit_valid),
    .bit_i        (rx_bit),
    .char_valid_o (char_valid),
    .char_o       (rx_char),
    .err_par_o    (err_par),
    .aligned_o    (aligned)
  );

  char_decoder u_dec (
    .gclk         (gclk),
    .reset        (reset),
    .char_valid_i (char_valid),
    .char_i       (rx_char),
    .aligned_i    (aligned),
    .link_run_i   (link_run_i),
    .fifo_full_i  (fifo_full_i),
    .event_o      (event_o),
    .err_esc_o    (err_esc),
    .got_null_o   (got_null_o),
    .fifo_wr_o    (fifo_wr_o),
    .nchar_o      (nchar_o),
    .tick_o       (tick_o),
    .time_o       (time_o)
  );

  credit_counter u_credit (
    .gclk          (gclk),
    .reset         (reset),
    .link_dsc_i    (link_dsc_o),
    .fct_sent_i    (fct_sent_i),
    .got_nchar_i   (event_o.got_nchar),
    .credit_o      (credit_o),
    .fct_request_o (fct_request_o)
  );

  assign err_o = '{parity: err_par, escape: err_esc, disconnect: err_dsc};

endmodule

// File: testbench/spw_receiver_chk.sv
`timescale 1ns/1ps

module spw_receiver_chk (
  input logic                              gclk,
  input logic                              reset,
  input logic                              link_run_i,
  input logic                              fifo_wr_o,
  input logic                              fifo_full_i,
  input spw_link_pkg::rx_event_t           event_o,
  input logic [spw_link_pkg::CREDIT_W-1:0] credit_o,
  input logic                              got_null_o
);
  import spw_link_pkg::*;

  // each reported n-char is written while running with room in the fifo
  // and a write is never issued into a full fifo
  wr_when_full: assert property (@(posedge gclk) disable iff (reset)
    fifo_wr_o == (event_o.got_nchar && link_run_i && !fifo_full_i))
    else $error("fifo write does not match n-char, run and full");

  credit_bound: assert property (@(posedge gclk) disable iff (reset)
    credit_o <= CREDIT_W'(CREDIT_MAX))
    else $error("credit above maximum");  // 56 is the ceiling

  // first NULL is sticky
  null_sticky: assert property (@(posedge gclk) disable iff (reset)
    !$fell(got_null_o))
    else $error("got_null_o fell outside reset");

endmodule

bind spw_receiver spw_receiver_chk u_chk (.*);

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic gclk_o,
  output logic reset_o
);

  initial
  begin
    gclk_o  = 1'b0;
    reset_o = 1'b1;
    repeat (16) @(posedge gclk_o);  // 16 cycles of reset
    #2 reset_o = 1'b0;
  end

  always #20 gclk_o = ~gclk_o;  // 40 ns period

endmodule

// File: testbench/tb_spw_receiver.sv
`timescale 1ns/1ps

module tb_spw_receiver;
  import spw_char_pkg::*;
  import spw_link_pkg::*;

  localparam int K_NOISE = 0, K_NULL = 1, K_DATA = 2, K_EOP = 3, K_EEP = 4;
  localparam int K_FCT = 5, K_TIME = 6, K_ESCERR = 7, K_RESET = 8, K_STOP = 9;

  // one table row, stimulus then expected outputs
  typedef struct packed {
    logic [3:0]          kind;
    logic [7:0]          payload;
    logic                bad_par;  // flip the parity bit
    logic                full;
    logic                run;
    logic                fct;      // pulse fct_sent_i before the character
    logic                wr;
    rx_event_t           ev;
    logic                tick;
    rx_err_t             err;
    logic                nul;      // got_null_o after the row
    logic [CREDIT_W-1:0] credit;
    logic                req;
  } row_t;

  logic gclk, reset, soft_rst;
  logic d_i, s_i, rx_enable_i, link_run_i, fct_sent_i, fifo_full_i;
  logic                fifo_wr_o, tick_o, got_null_o, link_dsc_o, fct_request_o;
  nchar_t              nchar_o;
  payload_u            time_o;
  rx_event_t           event_o;
  rx_err_t             err_o;
  logic [CREDIT_W-1:0] credit_o;

  row_t   rows[$];
  nchar_t wr_q[$];        // every fifo write seen
  int     c_fct, c_nev, c_tev, c_tick, c_par, c_esc, c_dsc;
  int     val_errs, other_errs;
  integer seed;
  logic   tail;           // xor of bits after the last flag sent

  tb_clock_gen u_clk (.gclk_o(gclk), .reset_o(reset));

  spw_receiver u_spw_receiver (
    .gclk(gclk), .reset(reset | soft_rst), .d_i(d_i), .s_i(s_i),
    .rx_enable_i(rx_enable_i), .link_run_i(link_run_i), .fct_sent_i(fct_sent_i),
    .fifo_full_i(fifo_full_i), .fifo_wr_o(fifo_wr_o), .nchar_o(nchar_o),
    .tick_o(tick_o), .time_o(time_o), .event_o(event_o), .err_o(err_o),
    .got_null_o(got_null_o), .link_dsc_o(link_dsc_o), .credit_o(credit_o),
    .fct_request_o(fct_request_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // output monitor, sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge gclk)
  begin
    if (fifo_wr_o)
      wr_q.push_back(nchar_o);
    c_fct  += event_o.got_fct;
    c_nev  += event_o.got_nchar;
    c_tev  += event_o.got_time;
    c_tick += tick_o;
    c_par  += err_o.parity;
    c_esc  += err_o.escape;
    c_dsc  += err_o.disconnect;
  end

  function automatic int activity_sum();
    return wr_q.size() + c_fct + c_nev + c_tev + c_tick + c_par + c_esc + c_dsc;
  endfunction

  task automatic compare_value(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      val_errs++;
    end
  endtask

  task automatic add_row(input int kind, input logic [7:0] payload, input logic [3:0] stim,
                         input logic wr, input logic [2:0] ev, input logic tick,
                         input logic [2:0] err, input logic nul, input int credit,
                         input logic req);
    row_t r;
    r = '{kind[3:0], payload, stim[3], stim[2], stim[1], stim[0], wr, ev, tick, err,
          nul, credit[CREDIT_W-1:0], req};
    rows.push_back(r);
  endtask

  // fifo word as the receiver must build it
  function automatic nchar_t expected_word(input int kind, input logic [7:0] payload);
    if (kind == K_EOP)
      return '{1'b1, 8'h00};
    if (kind == K_EEP)
      return '{1'b1, 8'h01};
    return '{1'b0, payload};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // data-strobe encoder
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_bit(input logic b);
    @(posedge gclk);
    #2;
    if (b != d_i)
      d_i = ~d_i;            // D carries the bit
    else
      s_i = ~s_i;            // otherwise S toggles
    repeat (3) @(posedge gclk);  // 4 cycles per bit
  endtask

  task automatic send_char(input logic ctrl, input logic [1:0] code,
                           input logic [7:0] data, input logic bad);
    logic t;
    t = 1'b0;
    send_bit(1'b1 ^ tail ^ ctrl ^ bad);  // odd parity over tail, parity, flag
    send_bit(ctrl);
    if (ctrl)
      for (int i = 0; i < 2; i++)
      begin
        send_bit(code[i]);
        t ^= code[i];
      end
    else
      for (int i = 0; i < 8; i++)
      begin
        send_bit(data[i]);
        t ^= data[i];
      end
    tail = t;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table and loop
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    row_t r;
    int   snap, snap_wr, snap_fct, snap_nev, snap_tev, snap_tick;
    int   snap_par, snap_esc, snap_dsc, n;
    logic snap_null;

    d_i = 0; s_i = 0; rx_enable_i = 1; link_run_i = 0;
    fct_sent_i = 0; fifo_full_i = 0; soft_rst = 0;
    c_fct = 0; c_nev = 0; c_tev = 0; c_tick = 0; c_par = 0; c_esc = 0; c_dsc = 0;
    val_errs = 0; other_errs = 0; tail = 0; seed = 26;

    // stim = bad_par, full, run, fct   ev = fct, nchar, time   err = par, esc, dsc
    add_row(K_NOISE,  8'h12,        4'b0000, 0, 3'b000, 0, 3'b000, 0, 0,  1);
    add_row(K_NULL,   8'h00,        4'b0011, 0, 3'b000, 0, 3'b000, 1, 8,  1);
    add_row(K_DATA,   8'h5a,        4'b0011, 1, 3'b010, 0, 3'b000, 1, 15, 1);
    add_row(K_DATA,   8'($random(seed)), 4'b0011, 1, 3'b010, 0, 3'b000, 1, 22, 1);
    add_row(K_EOP,    8'h00,        4'b0011, 1, 3'b010, 0, 3'b000, 1, 29, 1);
    add_row(K_EEP,    8'h00,        4'b0011, 1, 3'b010, 0, 3'b000, 1, 36, 1);
    add_row(K_FCT,    8'h00,        4'b0011, 0, 3'b100, 0, 3'b000, 1, 44, 1);
    add_row(K_DATA,   8'($random(seed)), 4'b0111, 0, 3'b010, 0, 3'b000, 1, 51, 0);
    add_row(K_TIME,   8'h95,        4'b0011, 0, 3'b001, 1, 3'b000, 1, 51, 0);  // no add
    add_row(K_TIME,   8'h2c,        4'b0000, 0, 3'b001, 0, 3'b000, 1, 51, 0);
    add_row(K_DATA,   8'($random(seed)), 4'b0000, 0, 3'b010, 0, 3'b000, 1, 50, 0);
    add_row(K_DATA,   8'($random(seed)), 4'b0010, 1, 3'b010, 0, 3'b000, 1, 49, 0);
    add_row(K_DATA,   8'($random(seed)), 4'b0010, 1, 3'b010, 0, 3'b000, 1, 48, 1);
    add_row(K_DATA,   8'($random(seed)), 4'b0010, 1, 3'b010, 0, 3'b000, 1, 47, 1);
    add_row(K_ESCERR, 8'h00,        4'b0010, 0, 3'b000, 0, 3'b010, 1, 47, 1);
    add_row(K_DATA,   8'h33,        4'b0010, 0, 3'b000, 0, 3'b000, 1, 47, 1);  // decoder halted
    add_row(K_RESET,  8'h00,        4'b0010, 0, 3'b000, 0, 3'b000, 0, 0,  1);
    add_row(K_NULL,   8'h00,        4'b0011, 0, 3'b000, 0, 3'b000, 1, 8,  1);
    add_row(K_DATA,   8'h81,        4'b1010, 0, 3'b000, 0, 3'b100, 1, 8,  1);
    add_row(K_DATA,   8'h44,        4'b0010, 0, 3'b000, 0, 3'b000, 1, 8,  1);  // assembler halted
    add_row(K_STOP,   8'h00,        4'b0010, 0, 3'b000, 0, 3'b001, 1, 0,  1);

    for (n = 0; n < 100 && reset; n++)
      @(posedge gclk);
    if (reset)
    begin
      $display("reset never released");
      other_errs++;
    end

    foreach (rows[k])
    begin
      r = rows[k];
      @(posedge gclk);
      #2;
      fifo_full_i = r.full;
      link_run_i  = r.run;
      if (r.fct)
      begin
        fct_sent_i = 1'b1;
        @(posedge gclk);
        #2 fct_sent_i = 1'b0;
      end
      snap_wr = wr_q.size(); snap_fct = c_fct; snap_nev = c_nev; snap_tev = c_tev;
      snap_tick = c_tick; snap_par = c_par; snap_esc = c_esc; snap_dsc = c_dsc;
      snap = activity_sum();
      snap_null = got_null_o;

      case (r.kind)
        K_NOISE:  for (int i = 0; i < 6; i++) send_bit(r.payload[i]);
        K_NULL:
        begin
          send_char(1'b1, CODE_ESC, 8'h00, 1'b0);
          send_char(1'b1, CODE_FCT, 8'h00, 1'b0);
        end
        K_DATA:   send_char(1'b0, 2'b00, r.payload, r.bad_par);
        K_EOP:    send_char(1'b1, CODE_EOP, 8'h00, 1'b0);
        K_EEP:    send_char(1'b1, CODE_EEP, 8'h00, 1'b0);
        K_FCT:    send_char(1'b1, CODE_FCT, 8'h00, 1'b0);
        K_TIME:
        begin
          send_char(1'b1, CODE_ESC, 8'h00, 1'b0);
          send_char(1'b0, 2'b00, r.payload, 1'b0);
        end
        K_ESCERR:
        begin
          send_char(1'b1, CODE_ESC, 8'h00, 1'b0);
          send_char(1'b1, CODE_EOP, 8'h00, 1'b0);
        end
        K_RESET:
        begin
          soft_rst = 1'b1;
          d_i = 1'b0;  // line back to idle with the synchronizers
          s_i = 1'b0;
          tail = 1'b0;
          repeat (16) @(posedge gclk);
          #2 soft_rst = 1'b0;
        end
        default: ;
      endcase

      if (r.kind == K_STOP)
      begin
        for (n = 0; n < 60 && !link_dsc_o; n++)
          @(negedge gclk);
        if (!link_dsc_o)
        begin
          $display("no disconnect after the lines went quiet");
          other_errs++;
        end
      end
      else
        // quiet rows simply run out, deltas below catch a missing output
        for (n = 0; n < 10 && activity_sum() == snap && got_null_o == snap_null; n++)
          @(negedge gclk);
      repeat (2) @(negedge gclk);  // credit follows one cycle later

      compare_value("fifo_wr_o count", wr_q.size() - snap_wr, r.wr);
      if (r.wr && wr_q.size() > snap_wr)
        compare_value("nchar_o", wr_q[wr_q.size()-1], expected_word(r.kind, r.payload));
      compare_value("got_fct", c_fct - snap_fct, r.ev.got_fct);
      compare_value("got_nchar", c_nev - snap_nev, r.ev.got_nchar);
      compare_value("got_time", c_tev - snap_tev, r.ev.got_time);
      compare_value("tick_o", c_tick - snap_tick, r.tick);
      if (r.ev.got_time)
        compare_value("time_o", time_o.data, r.payload);
      compare_value("err_o.parity", c_par - snap_par, r.err.parity);
      compare_value("err_o.escape", c_esc - snap_esc, r.err.escape);
      compare_value("err_o.disconnect", c_dsc - snap_dsc, r.err.disconnect);
      compare_value("link_dsc_o", link_dsc_o, r.err.disconnect);
      compare_value("got_null_o", got_null_o, r.nul);
      compare_value("credit_o", credit_o, r.credit);
      compare_value("fct_request_o", fct_request_o, r.req);
    end

    $display("value errors %0d, other errors %0d", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: list.f
common/spw_link_pkg.sv
common/spw_char_pkg.sv
design/ds_line_monitor.sv
char_rx/char_assembler.sv
char_rx/char_decoder.sv
design/credit_counter.sv
design/spw_receiver.sv
testbench/spw_receiver_chk.sv
testbench/tb_clock_gen.sv
testbench/tb_spw_receiver.sv

// File: Makefile
# Verilator flow for the SpaceWire receiver
TOP      ?= tb_spw_receiver
SEED     ?= 26
LOG      ?= sim.log
FILELIST ?= list.f
OBJ_DIR  ?= obj_dir
VERILATOR ?= verilator
VFLAGS   ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
